//--- source/hyperram_config.svh
/* Timing constants shared by the controller and the memory model.
   Latency is fixed at 2x, the RWDS latency flag is never looked at.
   POR wait is cut short for simulation, a real part needs 150 us. */
`ifndef HYPERRAM_CONFIG_SVH
`define HYPERRAM_CONFIG_SVH

// ------------------------------
// Bus framing
// ------------------------------
`define HR_CA_BYTES       6    // Command/address bytes, MSB first

// Byte slots of initial latency, two 6-clock periods at default config
`define HR_LATENCY_BYTES  24

// ------------------------------
// Core clock counts
// ------------------------------
`define HR_POR_CYCLES     120  // Wait after reset before first CS
`define HR_TCSHI_CYCLES   15   // CS high time between transactions

`endif

//--- source/hyperram_pkg.sv
/* Types shared by the HyperRAM controller blocks.
   CA word follows the HyperBus command/address bit layout. */
`default_nettype none

package hyperram_pkg;

  typedef logic [31:0] dword_t;
  typedef logic [3:0]  byte_en_t;  // Bit 3 is the first byte on the bus

  // 48-bit command/address, sent MSB first
  typedef struct packed {
    logic        rd;         // 1 = read, 0 = write
    logic        reg_space;  // 1 = register space
    logic        linear;     // Always linear burst
    logic [28:0] row_col;    // addr[31:3]
    logic [12:0] rsvd;       // Must be zero
    logic [2:0]  col_lo;     // addr[2:0]
  } ca_t;

  typedef struct packed {
    ca_t      ca;
    dword_t   data;
    byte_en_t be;
  } req_t;

  typedef enum logic [2:0] {POR, IDLE, ADDR, WAIT, DATA, GAP} phase_t;

endpackage

`default_nettype wire

//--- source/hyperram_bus_if.sv
/* Byte-slot link from the sequencer to the PHY.
   step comes back every second core clock while run is high. */
`default_nettype none

interface hyperram_bus_if;
  import hyperram_pkg::*;

  logic       run;       // DRAM clock on, CS low
  logic [7:0] out_byte;  // Next DQ byte
  logic       out_mask;  // RWDS level, 1 = byte not written
  logic       dq_oe;
  logic       rwds_oe;
  logic       step;      // One pulse per DRAM clock edge
  logic       rd_arm;    // Read capture enabled
  logic       rd_done;   // Four bytes collected
  dword_t     rd_word;

  modport seq (output run, out_byte, out_mask, dq_oe, rwds_oe, rd_arm,
               input  step, rd_done);

  modport phy (input  run, out_byte, out_mask, dq_oe, rwds_oe, rd_arm,
               output step, rd_done, rd_word);

endinterface

`default_nettype wire

//--- source/hyperram_req_capture.sv
/* Request input stage. Takes one rd_req or wr_req pulse while idle and
   holds it until the sequencer picks it up.
   Register reads are not supported and get dropped here. */
`default_nettype none

module hyperram_req_capture (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  rd_req,
  input  logic                  wr_req,
  input  logic                  mem_or_reg,
  input  hyperram_pkg::dword_t  addr,
  input  hyperram_pkg::dword_t  wr_d,
  input  hyperram_pkg::byte_en_t wr_byte_en,
  input  logic                  busy_seq,
  output hyperram_pkg::req_t    req,
  output logic                  req_valid,
  input  logic                  req_take
);
  import hyperram_pkg::*;

  ca_t  ca_next;
  logic accept;

  // Only when nothing is pending or running
  assign accept = !req_valid && !busy_seq && (wr_req || (rd_req && !mem_or_reg));

  always_comb begin
    ca_next           = '0;            // Reserved field stays zero
    ca_next.rd        = rd_req;
    ca_next.reg_space = mem_or_reg;
    ca_next.linear    = 1'b1;
    ca_next.row_col   = addr[31:3];
    ca_next.col_lo    = addr[2:0];     // Cfg reg 0 sits at 0x800
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      req_valid <= 1'b0;
    end else if (req_take) begin
      req_valid <= 1'b0;
    end else if (accept) begin
      req_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req <= '{ca: ca_next, data: wr_d, be: wr_byte_en};
    end
  end

  // Caller issues one kind of request at a time
  a_one_req: assert property (@(posedge clk) disable iff (!resetn) !(rd_req && wr_req));

endmodule

`default_nettype wire

//--- source/hyperram_sequencer.sv
/* Transaction sequencer. Counts POR, then ADDR, WAIT, DATA and GAP in
   byte slots given by the PHY step pulse.
   Latency is always the fixed 2x count. Register writes skip WAIT.
   A read ends when the PHY has four bytes, not on a slot count. */
`include "hyperram_config.svh"
`default_nettype none

module hyperram_sequencer (
  input  logic               clk,
  input  logic               resetn,
  input  hyperram_pkg::req_t req,
  input  logic               req_valid,
  output logic               req_take,
  hyperram_bus_if.seq        bus,
  output logic               busy
);
  import hyperram_pkg::*;

  localparam int POR_W = $clog2(`HR_POR_CYCLES + 1);
  localparam int CNT_W = $clog2(`HR_LATENCY_BYTES + 1);
  localparam int GAP_W = $clog2(`HR_TCSHI_CYCLES + 1);

  phase_t           phase;
  logic [POR_W-1:0] por_cnt;
  logic [CNT_W-1:0] cnt;       // Slots left in current phase
  logic [GAP_W-1:0] gap_cnt;
  logic [47:0]      ca_sr;
  dword_t           data_sr;
  byte_en_t         be_sr;
  logic             is_rd;
  logic             is_reg;

  assign req_take = (phase == IDLE) && req_valid;
  assign busy     = req_valid || !(phase inside {IDLE, POR});

  // ------------------------------
  // Phase control
  // ------------------------------
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      phase        <= POR;
      por_cnt      <= POR_W'(`HR_POR_CYCLES);
      cnt          <= '0;
      gap_cnt      <= '0;
      is_rd        <= 1'b0;
      is_reg       <= 1'b0;
      bus.run      <= 1'b0;
      bus.out_mask <= 1'b1;            // Idle RWDS high
      bus.dq_oe    <= 1'b0;
      bus.rwds_oe  <= 1'b0;
      bus.rd_arm   <= 1'b0;
    end else if (bus.rd_arm && bus.rd_done) begin
      phase      <= GAP;               // Read complete
      bus.run    <= 1'b0;
      bus.rd_arm <= 1'b0;
      gap_cnt    <= GAP_W'(`HR_TCSHI_CYCLES - 1);
    end else begin
      case (phase)
        POR: begin
          if (por_cnt == '0) phase <= IDLE;
          else               por_cnt <= por_cnt - 1'b1;
        end
        IDLE: begin
          if (req_valid) begin
            phase     <= ADDR;
            cnt       <= CNT_W'(`HR_CA_BYTES);
            is_rd     <= req.ca.rd;
            is_reg    <= req.ca.reg_space;
            bus.run   <= 1'b1;
            bus.dq_oe <= 1'b1;         // Host owns DQ for CA
          end
        end
        ADDR: begin
          if (bus.step) begin
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin
              if (is_reg && !is_rd) begin
                phase <= DATA;         // Zero latency reg write
                cnt   <= CNT_W'(2);
              end else begin
                phase <= WAIT;
                cnt   <= CNT_W'(`HR_LATENCY_BYTES);
              end
            end
          end
        end
        WAIT: begin
          if (bus.step) begin
            if (is_rd) begin
              bus.dq_oe  <= 1'b0;      // Hand DQ to the part
              bus.rd_arm <= 1'b1;
            end
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin
              phase <= DATA;
              cnt   <= CNT_W'(4);
            end
          end
        end
        DATA: begin
          // Reads leave through rd_done above
          if (bus.step && !is_rd) begin
            if (cnt != '0) begin
              bus.out_mask <= ~be_sr[3];
              bus.rwds_oe  <= !is_reg; // No mask on reg writes
              cnt          <= cnt - 1'b1;
            end else begin
              // Extra slot lets the last byte see its falling edge
              phase        <= GAP;
              bus.run      <= 1'b0;
              bus.dq_oe    <= 1'b0;
              bus.rwds_oe  <= 1'b0;
              bus.out_mask <= 1'b1;
              gap_cnt      <= GAP_W'(`HR_TCSHI_CYCLES - 1);
            end
          end
        end
        GAP: begin
          if (gap_cnt == '0) phase <= IDLE;
          else               gap_cnt <= gap_cnt - 1'b1;
        end
        default: phase <= IDLE;
      endcase
    end
  end

  // ------------------------------
  // Byte shifters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (req_take) begin
      ca_sr   <= req.ca;
      data_sr <= req.data;
      be_sr   <= req.be;
    end else if (bus.step && phase == ADDR) begin
      bus.out_byte <= ca_sr[47:40];
      ca_sr        <= {ca_sr[39:0], 8'h00};
    end else if (bus.step && phase == WAIT) begin
      bus.out_byte <= 8'h00;           // Latency filler
    end else if (bus.step && phase == DATA && !is_rd && cnt != '0) begin
      bus.out_byte <= data_sr[31:24];
      data_sr      <= {data_sr[23:0], 8'h00};
      be_sr        <= {be_sr[2:0], 1'b0};
    end
  end

  // PHY steps only with the clock running
  a_step_run: assert property (@(posedge clk) disable iff (!resetn) bus.step |-> bus.run);
  // No DQ contention while the part drives read data
  a_rd_no_drive: assert property (@(posedge clk) disable iff (!resetn)
    bus.rd_arm |-> !bus.dq_oe);

endmodule

`default_nettype wire

//--- source/hyperram_phy.sv
/* Pin side of the controller. DRAM clock is core clock / 4, which puts
   both DRAM clock edges mid-byte without a PLL.
   Every pin is registered. Read data is taken on each RWDS rise and two
   core clocks later, so RWDS must toggle in step with dram_ck. */
`default_nettype none

module hyperram_phy (
  input  logic                 clk,
  input  logic                 resetn,
  hyperram_bus_if.phy          bus,
  input  logic [7:0]           dram_dq_in,
  output logic [7:0]           dram_dq_out,
  output logic                 dram_dq_oe_l,
  input  logic                 dram_rwds_in,
  output logic                 dram_rwds_out,
  output logic                 dram_rwds_oe_l,
  output logic                 dram_ck,
  output logic                 dram_cs_l,
  output hyperram_pkg::dword_t rd_d,
  output logic                 rd_rdy
);

  logic [1:0] ck_phs;     // Divide-by-4 phase
  logic       ck_local;
  logic [7:0] dq_q;
  logic       rwds_q;
  logic       rwds_q1;
  logic       rise;
  logic [1:0] rise_sr;    // Rise delayed for second sample
  logic       sample;
  logic [1:0] byte_cnt;

  // ------------------------------
  // Clock divider and slot pulse
  // ------------------------------
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn)      ck_phs <= 2'd0;
    else if (bus.run) ck_phs <= ck_phs + 2'd1;
    else              ck_phs <= 2'd0;
  end

  assign bus.step = bus.run & ck_phs[0];  // Phases 1 and 3

  // ------------------------------
  // IO flops
  // ------------------------------
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ck_local       <= 1'b0;
      dram_ck        <= 1'b0;
      dram_cs_l      <= 1'b1;
      dram_dq_out    <= 8'h00;
      dram_dq_oe_l   <= 1'b1;
      dram_rwds_out  <= 1'b1;
      dram_rwds_oe_l <= 1'b1;
      rwds_q         <= 1'b0;
      rwds_q1        <= 1'b0;
    end else begin
      ck_local       <= bus.run & ck_phs[1];  // No stray pulse when run drops
      dram_ck        <= ck_local;
      dram_cs_l      <= ~bus.run;
      dram_dq_out    <= bus.out_byte;
      dram_dq_oe_l   <= ~bus.dq_oe;
      dram_rwds_out  <= bus.out_mask;         // 1 = byte masked
      dram_rwds_oe_l <= ~bus.rwds_oe;
      rwds_q         <= dram_rwds_in;
      rwds_q1        <= rwds_q;
    end
  end

  always_ff @(posedge clk) begin
    dq_q <= dram_dq_in;
  end

  // ------------------------------
  // Read deserializer
  // ------------------------------
  assign rise   = rwds_q & ~rwds_q1;
  assign sample = bus.rd_arm & (rise | rise_sr[1]);  // Rising then falling byte

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      rise_sr     <= 2'b00;
      byte_cnt    <= 2'd0;
      bus.rd_done <= 1'b0;
    end else if (!bus.rd_arm) begin
      rise_sr     <= 2'b00;
      byte_cnt    <= 2'd0;
      bus.rd_done <= 1'b0;
    end else begin
      rise_sr     <= {rise_sr[0], rise};
      bus.rd_done <= sample && (byte_cnt == 2'd3);
      if (sample) byte_cnt <= byte_cnt + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (sample) bus.rd_word <= {bus.rd_word[23:0], dq_q};  // MSB arrives first
  end

  // One-cycle strobe, data zero otherwise
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      rd_rdy <= 1'b0;
      rd_d   <= '0;
    end else begin
      rd_rdy <= bus.rd_done;
      rd_d   <= bus.rd_done ? bus.rd_word : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/hyperram_ctrl.sv
/* HyperRAM controller, one 32-bit access per request over 8-bit DDR.
   rd_req/wr_req are single-cycle pulses, ignored while busy is high.
   Part must stay in its default 2x latency, only Cfg reg 0 is writable. */
`default_nettype none

module hyperram_ctrl (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   rd_req,
  input  logic                   wr_req,
  input  logic                   mem_or_reg,     // 0 = memory, 1 = register
  input  hyperram_pkg::byte_en_t wr_byte_en,
  input  hyperram_pkg::dword_t   addr,           // Byte address
  input  hyperram_pkg::dword_t   wr_d,
  output hyperram_pkg::dword_t   rd_d,
  output logic                   rd_rdy,
  output logic                   busy,
  input  logic [7:0]             dram_dq_in,
  output logic [7:0]             dram_dq_out,
  output logic                   dram_dq_oe_l,
  input  logic                   dram_rwds_in,
  output logic                   dram_rwds_out,
  output logic                   dram_rwds_oe_l,
  output logic                   dram_ck,
  output logic                   dram_cs_l,
  output logic                   dram_rst_l
);

  hyperram_pkg::req_t req;
  logic               req_valid;
  logic               req_take;

  hyperram_bus_if bus ();

  assign dram_rst_l = resetn;  // Part reset tracks core reset

  hyperram_req_capture req_capture_i (
    .clk, .resetn, .rd_req, .wr_req, .mem_or_reg, .addr, .wr_d, .wr_byte_en,
    .busy_seq (busy), .req, .req_valid, .req_take
  );

  hyperram_sequencer sequencer_i (
    .clk, .resetn, .req, .req_valid, .req_take, .bus (bus.seq), .busy
  );

  hyperram_phy phy_i (
    .clk, .resetn, .bus (bus.phy),
    .dram_dq_in, .dram_dq_out, .dram_dq_oe_l,
    .dram_rwds_in, .dram_rwds_out, .dram_rwds_oe_l,
    .dram_ck, .dram_cs_l, .rd_d, .rd_rdy
  );

endmodule

`default_nettype wire

//--- test/hyperram_model.sv
/* Behavioral HyperRAM for simulation only. 256-byte array, byte address
   taken from the low bits of the CA word. Fixed 2x latency, register
   writes have zero latency and only Cfg reg 0 at 0x800 is kept.
   Reads return RWDS toggling with dram_ck, one byte per edge. */
`default_nettype none
`include "hyperram_config.svh"

module hyperram_model (
  input  logic       rst_l,
  input  logic       ck,
  input  logic       cs_l,
  input  logic [7:0] dq_in,     // From controller DQ out
  input  logic       rwds_in,   // Write mask from controller
  input  logic       rwds_oe_l,
  output logic [7:0] dq_out,
  output logic       rwds_out
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  mem [0:255];
  logic [15:0] cfg0;
  logic [7:0]  cfg_hi;          // First reg byte held until the second
  logic [47:0] ca;
  int          edge_cnt;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'h5a;   // Known start pattern
    end
    cfg0     = 16'h0000;
    cfg_hi   = 8'h00;
    ca       = '0;
    edge_cnt = 0;
    dq_out   = 8'h00;
    rwds_out = 1'b0;
  end

  // ------------------------------
  // Both clock edges carry a byte
  // ------------------------------
  always @(posedge ck or negedge ck or posedge cs_l) begin
    int         slot;
    logic [7:0] idx;
    logic [31:0] full_addr;
    logic       is_rd;
    logic       is_reg;
    if (cs_l || !rst_l) begin
      edge_cnt = 0;             // New transaction on next CS low
      rwds_out <= 1'b0;
    end else begin
      if (edge_cnt < `HR_CA_BYTES) begin
        ca = {ca[39:0], dq_in}; // CA arrives MSB first
      end else begin
        is_rd     = ca[47];
        is_reg    = ca[46];
        full_addr = {ca[44:16], ca[2:0]};
        slot      = edge_cnt - `HR_CA_BYTES;
        if (!(is_reg && !is_rd)) slot = slot - `HR_LATENCY_BYTES;
        idx = full_addr[7:0] + 8'(slot);
        if (is_rd && !is_reg) begin
          if (slot >= 0 && slot < 4) begin
            dq_out   <= mem[idx];
            rwds_out <= (slot % 2 == 0);  // High on rising-edge byte
          end else if (slot >= 4) begin
            rwds_out <= 1'b0;
          end
        end else if (is_reg && !is_rd) begin
          if (slot == 0) cfg_hi = dq_in;
          if (slot == 1 && full_addr == 32'h0000_0800) cfg0 = {cfg_hi, dq_in};
        end else if (!is_rd) begin
          // Masked bytes keep their old value
          if (slot >= 0 && slot < 4 && !rwds_oe_l && !rwds_in) mem[idx] = dq_in;
        end
      end
      edge_cnt++;
    end
  end

endmodule

`default_nettype wire

//--- test/tb_hyperram_ctrl.sv
/* Testbench for the HyperRAM controller with the behavioral model on the
   pins. Addresses stay dword aligned inside the model's 256 bytes.
   Stops at the first error. */
`default_nettype none
`include "hyperram_config.svh"

module tb_hyperram_ctrl;
  timeunit 1ns;
  timeprecision 1ps;
  import hyperram_pkg::*;

  localparam int NUM_TRANS  = 33;   // All requests issued below
  localparam int WDOG_CYCLES = NUM_TRANS * 400 + `HR_POR_CYCLES + 8;

  logic       clk, resetn, rd_req, wr_req, mem_or_reg, rd_rdy, busy;
  byte_en_t   wr_byte_en;
  dword_t     addr, wr_d, rd_d;
  logic [7:0] dram_dq_in, dram_dq_out;
  logic       dram_dq_oe_l, dram_rwds_in, dram_rwds_out, dram_rwds_oe_l;
  logic       dram_ck, dram_cs_l, dram_rst_l;

  dword_t     shadow [0:63];        // Expected memory, one dword per entry
  dword_t     exp_q [$];            // Pending read results
  logic       rd_rdy_q;
  int         seed;

  hyperram_ctrl hyperram_ctrl_i (.*);

  hyperram_model model_i (
    .rst_l (dram_rst_l), .ck (dram_ck), .cs_l (dram_cs_l), .dq_in (dram_dq_out),
    .rwds_in (dram_rwds_out), .rwds_oe_l (dram_rwds_oe_l),
    .dq_out (dram_dq_in), .rwds_out (dram_rwds_in)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic dword_t start_pattern(input logic [7:0] a);
    return {a ^ 8'h5a, (a + 8'd1) ^ 8'h5a, (a + 8'd2) ^ 8'h5a, (a + 8'd3) ^ 8'h5a};
  endfunction

  function automatic dword_t merge_bytes(input dword_t old, input dword_t nw,
                                         input byte_en_t be);
    dword_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = nw[b*8 +: 8];   // be[3] is the MSB byte
    end
    return res;
  endfunction

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic stop_run(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // ------------------------------
  // Request helpers
  // ------------------------------
  task automatic start_req(input logic rd, input logic wr, input logic is_reg,
                           input dword_t a, input dword_t d, input byte_en_t be);
    @(posedge clk);
    while (busy) @(posedge clk);
    rd_req     <= rd;
    wr_req     <= wr;
    mem_or_reg <= is_reg;
    addr       <= a;
    wr_d       <= d;
    wr_byte_en <= be;
    @(posedge clk);
    rd_req <= 1'b0;
    wr_req <= 1'b0;
    @(posedge clk);
    check_value("busy", {31'b0, busy}, 32'd1);    // Rises one cycle after accept
  endtask

  task automatic wait_done;
    while (busy) @(posedge clk);
  endtask

  task automatic mem_write(input dword_t a, input dword_t d, input byte_en_t be);
    start_req(1'b0, 1'b1, 1'b0, a, d, be);
    shadow[a[7:2]] = merge_bytes(shadow[a[7:2]], d, be);
    wait_done();
  endtask

  task automatic mem_read(input dword_t a);
    exp_q.push_back(shadow[a[7:2]]);
    start_req(1'b1, 1'b0, 1'b0, a, 32'h0, 4'h0);
    wait_done();
  endtask

  // Compare every rd_rdy against the shadow copy
  always @(posedge clk) begin
    if (resetn) begin
      if (rd_rdy) begin
        if (rd_rdy_q) stop_run("rd_rdy stayed high for more than one cycle");
        if (exp_q.size() == 0) stop_run("rd_rdy pulsed with no read pending");
        check_value("rd_d", rd_d, exp_q.pop_front());
      end else begin
        check_value("rd_d", rd_d, 32'h0);         // Zero outside the strobe
      end
    end
    rd_rdy_q <= rd_rdy;
  end

  // Watchdog
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Error at %0t: watchdog expired, the DUT stopped responding", $time);
    $display("Simulation failed");
    $fatal(1);
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    dword_t   a;
    dword_t   d;
    byte_en_t be;
    seed       = 32'hd67c4401;
    resetn     = 1'b0;
    rd_req     = 1'b0;
    wr_req     = 1'b0;
    mem_or_reg = 1'b0;
    addr       = '0;
    wr_d       = '0;
    wr_byte_en = '0;
    rd_rdy_q   = 1'b0;
    for (int w = 0; w < 64; w++) shadow[w] = start_pattern(8'(w * 4));

    repeat (4) @(posedge clk);
    // Idle outputs while in reset
    check_value("busy", {31'b0, busy}, 32'd0);
    check_value("rd_rdy", {31'b0, rd_rdy}, 32'd0);
    check_value("dram_cs_l", {31'b0, dram_cs_l}, 32'd1);
    check_value("dram_ck", {31'b0, dram_ck}, 32'd0);
    check_value("dram_rwds_out", {31'b0, dram_rwds_out}, 32'd1);
    check_value("dram_dq_oe_l", {31'b0, dram_dq_oe_l}, 32'd1);
    check_value("dram_rwds_oe_l", {31'b0, dram_rwds_oe_l}, 32'd1);
    check_value("dram_rst_l", {31'b0, dram_rst_l}, 32'd0);
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    check_value("dram_rst_l", {31'b0, dram_rst_l}, 32'd1);

    mem_read(32'h0000_0040);                      // Untouched location
    mem_write(32'h0000_0010, 32'hdead_beef, 4'hf);
    mem_read(32'h0000_0010);
    mem_write(32'h0000_0020, 32'h1122_3344, 4'he);
    mem_write(32'h0000_0024, 32'h5566_7788, 4'h5);
    mem_write(32'h0000_0028, 32'h99aa_bbcc, 4'h0);
    mem_read(32'h0000_0024);
    mem_read(32'h0000_0020);
    mem_read(32'h0000_0028);                      // All bytes masked

    // Cfg reg 0 write, memory must not move
    start_req(1'b0, 1'b1, 1'b1, 32'h0000_0800, 32'h8f1f_0000, 4'hf);
    wait_done();
    check_value("cfg0", {16'h0, model_i.cfg0}, 32'h0000_8f1f);
    mem_read(32'h0000_0000);

    // Requests while busy are dropped
    start_req(1'b0, 1'b1, 1'b0, 32'h0000_0030, 32'h0102_0304, 4'hf);
    shadow[12] = merge_bytes(shadow[12], 32'h0102_0304, 4'hf);
    repeat (10) @(posedge clk);
    rd_req <= 1'b1;
    @(posedge clk);
    rd_req <= 1'b0;
    repeat (10) @(posedge clk);
    wr_req <= 1'b1;
    wr_d   <= 32'hffff_ffff;
    @(posedge clk);
    wr_req <= 1'b0;
    wait_done();
    mem_read(32'h0000_0030);

    for (int n = 0; n < 20; n++) begin
      a  = $random(seed) & 32'h0000_00fc;
      d  = $random(seed);
      be = 4'($random(seed));
      if ($random(seed) & 1) mem_read(a);
      else                   mem_write(a, d, be);
    end

    repeat (20) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("Error at %0t: a read finished without an rd_rdy pulse", $time);
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/hyperram_pkg.sv
source/hyperram_bus_if.sv
source/hyperram_req_capture.sv
source/hyperram_sequencer.sv
source/hyperram_phy.sv
source/hyperram_ctrl.sv
test/hyperram_model.sv
test/tb_hyperram_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

verilator --binary --timing -Wno-fatal --top-module tb_hyperram_ctrl \
  -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
